/* hw/ctrlPkg.sv */
package ctrlPkg;

	//**************************************************************************
	// Instruction encodings
	//**************************************************************************

	typedef enum logic [5:0] {
		OpRType  = 6'b000000,
		OpRegImm = 6'b000001,
		OpJ      = 6'b000010,
		OpJal    = 6'b000011,
		OpBeq    = 6'b000100,
		OpBne    = 6'b000101,
		OpBlez   = 6'b000110,
		OpBgtz   = 6'b000111,
		OpAddi   = 6'b001000,
		OpAddiu  = 6'b001001,
		OpSlti   = 6'b001010,
		OpSltiu  = 6'b001011,
		OpAndi   = 6'b001100,
		OpOri    = 6'b001101,
		OpXori   = 6'b001110,
		OpLui    = 6'b001111,
		OpLb     = 6'b100000,
		OpLh     = 6'b100001,
		OpLw     = 6'b100011,
		OpLbu    = 6'b100100,
		OpLhu    = 6'b100101,
		OpSb     = 6'b101000,
		OpSh     = 6'b101001,
		OpSw     = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		FnSll     = 6'b000000,
		FnSrl     = 6'b000010,
		FnSra     = 6'b000011,
		FnSllv    = 6'b000100,
		FnSrlv    = 6'b000110,
		FnSrav    = 6'b000111,
		FnJr      = 6'b001000,
		FnJalr    = 6'b001001,
		FnSyscall = 6'b001100,
		FnBreak   = 6'b001101,
		FnMfhi    = 6'b010000,
		FnMthi    = 6'b010001,
		FnMflo    = 6'b010010,
		FnMtlo    = 6'b010011,
		FnMult    = 6'b011000,
		FnMultu   = 6'b011001,
		FnDiv     = 6'b011010,
		FnDivu    = 6'b011011,
		FnAdd     = 6'b100000,
		FnAddu    = 6'b100001,
		FnSub     = 6'b100010,
		FnSubu    = 6'b100011,
		FnAnd     = 6'b100100,
		FnOr      = 6'b100101,
		FnXor     = 6'b100110,
		FnNor     = 6'b100111,
		FnSlt     = 6'b101010,
		FnSltu    = 6'b101011
	} funct_t;

	// rt field of the REGIMM group
	localparam logic [4:0] RtBltz   = 5'b00000;
	localparam logic [4:0] RtBgez   = 5'b00001;
	localparam logic [4:0] RtBltzal = 5'b10000;
	localparam logic [4:0] RtBgezal = 5'b10001;

	//**************************************************************************
	// Control word fields
	//**************************************************************************

	typedef enum logic [4:0] {
		AluAdd  = 5'b00000,
		AluSub  = 5'b00001,
		AluOr   = 5'b00010,
		AluAnd  = 5'b00011,
		AluNor  = 5'b00100,
		AluXor  = 5'b00101,
		AluSll  = 5'b00110,
		AluSrl  = 5'b00111,
		AluSra  = 5'b01000,
		AluSlt  = 5'b01001,
		AluSltu = 5'b01010,
		AluAddu = 5'b01100,
		AluSubu = 5'b10000,
		AluNone = 5'b11111
	} aluOp_t;

	typedef enum logic [3:0] {MduMultu = 4'd0, MduMult = 4'd1, MduDivu = 4'd2, MduDiv = 4'd3} mduOp_t;
	typedef enum logic [1:0] {NpcSeq, NpcBranch, NpcJump, NpcJumpReg} npcOp_t;
	typedef enum logic [1:0] {ExtZero, ExtSign, ExtUpper} extOp_t;
	typedef enum logic [2:0] {WbHiLo, WbUpper, WbAlu, WbLink, WbMem} wbSel_t;
	typedef enum logic [1:0] {DstRt, DstRd, DstRa} dstSel_t;
	typedef enum logic [1:0] {HiloLo, HiloHi, HiloMdu} hiloWrSel_t;

	// Access size, None shares the word encoding since the strobes qualify it
	typedef logic [2:0] memSize_t;
	localparam memSize_t MemSb   = 3'b000;
	localparam memSize_t MemSh   = 3'b001;
	localparam memSize_t MemSw   = 3'b010;
	localparam memSize_t MemLbu  = 3'b011;
	localparam memSize_t MemLb   = 3'b100;
	localparam memSize_t MemLhu  = 3'b101;
	localparam memSize_t MemLh   = 3'b110;
	localparam memSize_t MemLw   = 3'b111;
	localparam memSize_t MemNone = 3'b111;

	// Exception codes, fetch codes arrive from the fetch stage unchanged
	typedef logic [4:0] excCode_t;
	localparam excCode_t ExcNone = 5'd0;
	localparam excCode_t ExcSys  = 5'd8;
	localparam excCode_t ExcBp   = 5'd9;
	localparam excCode_t ExcRi   = 5'd10;

endpackage

/* hw/aluDecode.sv */
module aluDecode (
	input  ctrlPkg::opcode_t op,
	input  ctrlPkg::funct_t  funct,
	output ctrlPkg::aluOp_t  aluOp,
	output logic             shamtSel,
	output ctrlPkg::extOp_t  extOp,
	output logic             immSrc
);

	always_comb begin
		aluOp = ctrlPkg::AluNone;
		case (op)
			ctrlPkg::OpRType:
				case (funct)
					ctrlPkg::FnAdd:  aluOp = ctrlPkg::AluAdd;
					ctrlPkg::FnAddu: aluOp = ctrlPkg::AluAddu;
					ctrlPkg::FnSub:  aluOp = ctrlPkg::AluSub;
					ctrlPkg::FnSubu: aluOp = ctrlPkg::AluSubu;
					ctrlPkg::FnAnd:  aluOp = ctrlPkg::AluAnd;
					ctrlPkg::FnOr:   aluOp = ctrlPkg::AluOr;
					ctrlPkg::FnXor:  aluOp = ctrlPkg::AluXor;
					ctrlPkg::FnNor:  aluOp = ctrlPkg::AluNor;
					ctrlPkg::FnSll, ctrlPkg::FnSllv: aluOp = ctrlPkg::AluSll;
					ctrlPkg::FnSrl, ctrlPkg::FnSrlv: aluOp = ctrlPkg::AluSrl;
					ctrlPkg::FnSra, ctrlPkg::FnSrav: aluOp = ctrlPkg::AluSra;
					ctrlPkg::FnSlt:  aluOp = ctrlPkg::AluSlt;
					ctrlPkg::FnSltu: aluOp = ctrlPkg::AluSltu;
					default:         aluOp = ctrlPkg::AluNone;
				endcase
			ctrlPkg::OpAddi:  aluOp = ctrlPkg::AluAdd;
			ctrlPkg::OpAddiu: aluOp = ctrlPkg::AluAddu;
			ctrlPkg::OpSlti:  aluOp = ctrlPkg::AluSlt;
			ctrlPkg::OpSltiu: aluOp = ctrlPkg::AluSltu;
			ctrlPkg::OpAndi:  aluOp = ctrlPkg::AluAnd;
			ctrlPkg::OpOri:   aluOp = ctrlPkg::AluOr;
			ctrlPkg::OpXori:  aluOp = ctrlPkg::AluXor;
			ctrlPkg::OpLb, ctrlPkg::OpLbu, ctrlPkg::OpLh, ctrlPkg::OpLhu, ctrlPkg::OpLw,
			ctrlPkg::OpSb, ctrlPkg::OpSh, ctrlPkg::OpSw: aluOp = ctrlPkg::AluAdd;	// Address add
			default:          aluOp = ctrlPkg::AluNone;
		endcase
	end

	// Constant shifts take shamt instead of rs
	assign shamtSel = (op == ctrlPkg::OpRType) &&
		(funct == ctrlPkg::FnSll || funct == ctrlPkg::FnSrl || funct == ctrlPkg::FnSra);

	always_comb begin
		immSrc = 1'b1;
		extOp = ctrlPkg::ExtSign;
		case (op)
			ctrlPkg::OpAddi, ctrlPkg::OpAddiu, ctrlPkg::OpSlti, ctrlPkg::OpSltiu,
			ctrlPkg::OpLb, ctrlPkg::OpLbu, ctrlPkg::OpLh, ctrlPkg::OpLhu, ctrlPkg::OpLw,
			ctrlPkg::OpSb, ctrlPkg::OpSh, ctrlPkg::OpSw: extOp = ctrlPkg::ExtSign;
			ctrlPkg::OpAndi, ctrlPkg::OpOri, ctrlPkg::OpXori: extOp = ctrlPkg::ExtZero;	// Logical ops
			ctrlPkg::OpLui: extOp = ctrlPkg::ExtUpper;
			default: begin
				immSrc = 1'b0;	// Register operand B
				extOp = ctrlPkg::ExtZero;
			end
		endcase
	end

endmodule

/* hw/branchDecode.sv */
module branchDecode (
	input  logic             clk,
	input  logic             rst,
	input  ctrlPkg::opcode_t op,
	input  ctrlPkg::funct_t  funct,
	input  logic [4:0]       rt,
	input  logic             rsEqRt,
	input  logic             rsNeg,
	input  logic             rsPos,	// rs > 0
	input  logic             instrValid,
	output logic             isBranch,
	output ctrlPkg::npcOp_t  npcOp,
	output logic             inDelaySlot
);

	logic taken;

	//**************************************************************************
	// Branch class and condition resolution
	//**************************************************************************

	always_comb begin
		isBranch = 1'b1;
		taken = 1'b0;
		npcOp = ctrlPkg::NpcSeq;
		case (op)
			ctrlPkg::OpBeq:  taken = rsEqRt;
			ctrlPkg::OpBne:  taken = !rsEqRt;
			ctrlPkg::OpBlez: taken = !rsPos;
			ctrlPkg::OpBgtz: taken = rsPos;
			ctrlPkg::OpRegImm:
				case (rt)
					ctrlPkg::RtBgez, ctrlPkg::RtBgezal: taken = !rsNeg;
					ctrlPkg::RtBltz, ctrlPkg::RtBltzal: taken = rsNeg;
					default: isBranch = 1'b0;	// Unknown rt is not a branch
				endcase
			ctrlPkg::OpJ, ctrlPkg::OpJal: npcOp = ctrlPkg::NpcJump;
			ctrlPkg::OpRType:
				if (funct == ctrlPkg::FnJr || funct == ctrlPkg::FnJalr) begin
					npcOp = ctrlPkg::NpcJumpReg;
				end else begin
					isBranch = 1'b0;
				end
			default: isBranch = 1'b0;
		endcase
		if (taken) begin
			npcOp = ctrlPkg::NpcBranch;
		end
	end

	// Delay slot marker for the next valid instruction
	always_ff @(posedge clk) begin
		if (!rst) begin
			inDelaySlot <= 1'b0;
		end else if (instrValid) begin
			inDelaySlot <= isBranch;
		end
	end

	npcSeqWhenNoBranch: assert property (@(posedge clk) disable iff (!rst)
		!isBranch |-> npcOp == ctrlPkg::NpcSeq)
		else $error("npcOp %0d without a branch", npcOp);

endmodule

/* hw/memDecode.sv */
module memDecode (
	input  ctrlPkg::opcode_t  op,
	output logic              dmRd,
	output logic              dmWr,
	output ctrlPkg::memSize_t dmSize,
	output logic              dcacheEn
);

	always_comb begin
		dmRd = 1'b0;
		dmWr = 1'b0;
		dmSize = ctrlPkg::MemNone;
		case (op)
			ctrlPkg::OpLb: begin
				dmRd = 1'b1;
				dmSize = ctrlPkg::MemLb;
			end
			ctrlPkg::OpLbu: begin
				dmRd = 1'b1;
				dmSize = ctrlPkg::MemLbu;
			end
			ctrlPkg::OpLh: begin
				dmRd = 1'b1;
				dmSize = ctrlPkg::MemLh;
			end
			ctrlPkg::OpLhu: begin
				dmRd = 1'b1;
				dmSize = ctrlPkg::MemLhu;
			end
			ctrlPkg::OpLw: begin
				dmRd = 1'b1;
				dmSize = ctrlPkg::MemLw;
			end
			ctrlPkg::OpSb: begin
				dmWr = 1'b1;
				dmSize = ctrlPkg::MemSb;
			end
			ctrlPkg::OpSh: begin
				dmWr = 1'b1;
				dmSize = ctrlPkg::MemSh;
			end
			ctrlPkg::OpSw: begin
				dmWr = 1'b1;
				dmSize = ctrlPkg::MemSw;
			end
			default: dmSize = ctrlPkg::MemNone;
		endcase
	end

	assign dcacheEn = dmRd | dmWr;	// Any data cache access

	// Checked on every opcode change
	noReadAndWrite: assert property (@(op) !(dmRd && dmWr))
		else $error("dmRd and dmWr both set");

endmodule

/* hw/hiloDecode.sv */
module hiloDecode (
	input  ctrlPkg::opcode_t    op,
	input  ctrlPkg::funct_t     funct,
	output logic                hiloWr,
	output logic                mduStart,
	output ctrlPkg::mduOp_t     mduOp,
	output ctrlPkg::hiloWrSel_t hiloWrSel,
	output logic                hiloRdHi,
	output logic                hiloBusy
);

	logic isR;

	assign isR = (op == ctrlPkg::OpRType);

	always_comb begin
		hiloWr = 1'b0;
		mduStart = 1'b0;
		mduOp = ctrlPkg::MduMultu;
		hiloWrSel = ctrlPkg::HiloLo;
		hiloRdHi = 1'b0;
		hiloBusy = 1'b0;
		if (isR) begin
			case (funct)
				ctrlPkg::FnMult, ctrlPkg::FnMultu, ctrlPkg::FnDiv, ctrlPkg::FnDivu: begin
					hiloWr = 1'b1;
					mduStart = 1'b1;	// Multi-cycle unit kicks off
					hiloWrSel = ctrlPkg::HiloMdu;
					hiloBusy = 1'b1;
				end
				ctrlPkg::FnMthi: begin
					hiloWr = 1'b1;
					hiloWrSel = ctrlPkg::HiloHi;
					hiloBusy = 1'b1;
				end
				ctrlPkg::FnMtlo: begin
					hiloWr = 1'b1;
					hiloBusy = 1'b1;
				end
				ctrlPkg::FnMfhi: begin
					hiloRdHi = 1'b1;
					hiloBusy = 1'b1;
				end
				ctrlPkg::FnMflo: hiloBusy = 1'b1;	// Reads LO
				default: hiloBusy = 1'b0;
			endcase
			case (funct)
				ctrlPkg::FnMult: mduOp = ctrlPkg::MduMult;
				ctrlPkg::FnDivu: mduOp = ctrlPkg::MduDivu;
				ctrlPkg::FnDiv:  mduOp = ctrlPkg::MduDiv;
				default:         mduOp = ctrlPkg::MduMultu;
			endcase
		end
	end

endmodule

/* hw/writebackDecode.sv */
module writebackDecode (
	input  ctrlPkg::opcode_t op,
	input  ctrlPkg::funct_t  funct,
	input  logic [4:0]       rt,
	output logic             rfWr,
	output ctrlPkg::dstSel_t dstSel,
	output ctrlPkg::wbSel_t  wbSel
);

	logic linkBranch;

	// BGEZAL and BLTZAL write the return address
	assign linkBranch = (op == ctrlPkg::OpRegImm) &&
		(rt == ctrlPkg::RtBgezal || rt == ctrlPkg::RtBltzal);

	always_comb begin
		rfWr = 1'b1;
		dstSel = ctrlPkg::DstRt;
		wbSel = ctrlPkg::WbAlu;
		case (op)
			ctrlPkg::OpRType: begin
				dstSel = ctrlPkg::DstRd;
				case (funct)
					ctrlPkg::FnJalr: wbSel = ctrlPkg::WbLink;
					ctrlPkg::FnMfhi, ctrlPkg::FnMflo: wbSel = ctrlPkg::WbHiLo;
					ctrlPkg::FnJr, ctrlPkg::FnSyscall, ctrlPkg::FnBreak, ctrlPkg::FnMthi,
					ctrlPkg::FnMtlo, ctrlPkg::FnMult, ctrlPkg::FnMultu, ctrlPkg::FnDiv,
					ctrlPkg::FnDivu: rfWr = 1'b0;
					default: rfWr = (funct inside {ctrlPkg::FnSll, ctrlPkg::FnSrl,
						ctrlPkg::FnSra, ctrlPkg::FnSllv, ctrlPkg::FnSrlv, ctrlPkg::FnSrav,
						ctrlPkg::FnAdd, ctrlPkg::FnAddu, ctrlPkg::FnSub, ctrlPkg::FnSubu,
						ctrlPkg::FnAnd, ctrlPkg::FnOr, ctrlPkg::FnXor, ctrlPkg::FnNor,
						ctrlPkg::FnSlt, ctrlPkg::FnSltu});
				endcase
			end
			ctrlPkg::OpAddi, ctrlPkg::OpAddiu, ctrlPkg::OpSlti, ctrlPkg::OpSltiu,
			ctrlPkg::OpAndi, ctrlPkg::OpOri, ctrlPkg::OpXori: wbSel = ctrlPkg::WbAlu;
			ctrlPkg::OpLui: wbSel = ctrlPkg::WbUpper;
			ctrlPkg::OpLb, ctrlPkg::OpLbu, ctrlPkg::OpLh, ctrlPkg::OpLhu,
			ctrlPkg::OpLw: wbSel = ctrlPkg::WbMem;
			ctrlPkg::OpJal: begin
				dstSel = ctrlPkg::DstRa;	// r31
				wbSel = ctrlPkg::WbLink;
			end
			ctrlPkg::OpRegImm: begin
				rfWr = linkBranch;
				dstSel = linkBranch ? ctrlPkg::DstRa : ctrlPkg::DstRt;
				wbSel = linkBranch ? ctrlPkg::WbLink : ctrlPkg::WbAlu;
			end
			default: rfWr = 1'b0;	// Stores, branches, J and unknown
		endcase
	end

endmodule

/* hw/excDecode.sv */
module excDecode (
	input  logic               clk,
	input  logic               rst,
	input  ctrlPkg::opcode_t   op,
	input  ctrlPkg::funct_t    funct,
	input  logic               rfWr,
	input  logic               hiloWr,
	input  logic               dmWr,
	input  logic               isBranch,
	input  logic               flush,
	input  logic               fetchExc,
	input  ctrlPkg::excCode_t  fetchExcCode,
	output logic               exception,
	output ctrlPkg::excCode_t  excCode
);

	logic rstGuard;	// Set for the first cycle out of reset
	logic isBreak;
	logic isSyscall;
	logic known;

	always_ff @(posedge clk) begin
		rstGuard <= !rst;
	end

	assign isBreak = (op == ctrlPkg::OpRType) && (funct == ctrlPkg::FnBreak);
	assign isSyscall = (op == ctrlPkg::OpRType) && (funct == ctrlPkg::FnSyscall);

	// Anything that drives some datapath action is a legal instruction
	assign known = rfWr | hiloWr | dmWr | isBranch | (op == ctrlPkg::OpJ) | isBreak | isSyscall;

	always_comb begin
		exception = 1'b1;
		excCode = ctrlPkg::ExcNone;
		if (fetchExc) begin
			excCode = fetchExcCode;	// Earlier stage wins
		end else if (!known && !flush && !rstGuard) begin
			excCode = ctrlPkg::ExcRi;
		end else if (isBreak) begin
			excCode = ctrlPkg::ExcBp;
		end else if (isSyscall) begin
			excCode = ctrlPkg::ExcSys;
		end else begin
			exception = 1'b0;
		end
	end

	codeZeroWhenIdle: assert property (@(posedge clk) disable iff (!rst)
		!exception |-> excCode == ctrlPkg::ExcNone)
		else $error("excCode %0d with no exception", excCode);

endmodule

/* hw/idControl.sv */
module idControl (
	input  logic                clk,
	input  logic                rst,
	input  logic [31:0]         instr,
	input  logic                instrValid,
	input  logic                rsEqRt,
	input  logic                rsNeg,
	input  logic                rsPos,
	input  logic                flush,
	input  logic                fetchExc,
	input  ctrlPkg::excCode_t   fetchExcCode,
	output logic                ctrlValid,
	output ctrlPkg::aluOp_t     aluOp,
	output logic                shamtSel,
	output ctrlPkg::extOp_t     extOp,
	output logic                immSrc,
	output logic                isBranch,
	output ctrlPkg::npcOp_t     npcOp,
	output logic                inDelaySlot,
	output logic                dmRd,
	output logic                dmWr,
	output ctrlPkg::memSize_t   dmSize,
	output logic                dcacheEn,
	output logic                hiloWr,
	output logic                mduStart,
	output ctrlPkg::mduOp_t     mduOp,
	output ctrlPkg::hiloWrSel_t hiloWrSel,
	output logic                hiloRdHi,
	output logic                hiloBusy,
	output logic                rfWr,
	output ctrlPkg::dstSel_t    dstSel,
	output ctrlPkg::wbSel_t     wbSel,
	output logic                exception,
	output ctrlPkg::excCode_t   excCode
);

	ctrlPkg::opcode_t    op;
	ctrlPkg::funct_t     funct;
	logic [4:0]          rt;
	ctrlPkg::aluOp_t     aluOpDec;
	logic                shamtSelDec;
	ctrlPkg::extOp_t     extOpDec;
	logic                immSrcDec;
	logic                isBranchDec;
	ctrlPkg::npcOp_t     npcOpDec;
	logic                inDelaySlotDec;
	logic                dmRdDec;
	logic                dmWrDec;
	ctrlPkg::memSize_t   dmSizeDec;
	logic                dcacheEnDec;
	logic                hiloWrDec;
	logic                mduStartDec;
	ctrlPkg::mduOp_t     mduOpDec;
	ctrlPkg::hiloWrSel_t hiloWrSelDec;
	logic                hiloRdHiDec;
	logic                hiloBusyDec;
	logic                rfWrDec;
	ctrlPkg::dstSel_t    dstSelDec;
	ctrlPkg::wbSel_t     wbSelDec;
	logic                exceptionDec;
	ctrlPkg::excCode_t   excCodeDec;

	assign op = ctrlPkg::opcode_t'(instr[31:26]);
	assign rt = instr[20:16];
	assign funct = ctrlPkg::funct_t'(instr[5:0]);

	aluDecode u_alu (.op(op), .funct(funct), .aluOp(aluOpDec), .shamtSel(shamtSelDec),
		.extOp(extOpDec), .immSrc(immSrcDec));

	branchDecode u_branch (.clk(clk), .rst(rst), .op(op), .funct(funct), .rt(rt),
		.rsEqRt(rsEqRt), .rsNeg(rsNeg), .rsPos(rsPos), .instrValid(instrValid),
		.isBranch(isBranchDec), .npcOp(npcOpDec), .inDelaySlot(inDelaySlotDec));

	memDecode u_mem (.op(op), .dmRd(dmRdDec), .dmWr(dmWrDec), .dmSize(dmSizeDec),
		.dcacheEn(dcacheEnDec));

	hiloDecode u_hilo (.op(op), .funct(funct), .hiloWr(hiloWrDec), .mduStart(mduStartDec),
		.mduOp(mduOpDec), .hiloWrSel(hiloWrSelDec), .hiloRdHi(hiloRdHiDec),
		.hiloBusy(hiloBusyDec));

	writebackDecode u_wb (.op(op), .funct(funct), .rt(rt), .rfWr(rfWrDec),
		.dstSel(dstSelDec), .wbSel(wbSelDec));

	excDecode u_exc (.clk(clk), .rst(rst), .op(op), .funct(funct), .rfWr(rfWrDec),
		.hiloWr(hiloWrDec), .dmWr(dmWrDec), .isBranch(isBranchDec), .flush(flush),
		.fetchExc(fetchExc), .fetchExcCode(fetchExcCode), .exception(exceptionDec),
		.excCode(excCodeDec));

	//**************************************************************************
	// ID/EX stage register
	//**************************************************************************

	always_ff @(posedge clk) begin
		if (!rst || !instrValid) begin	// Empty slot carries no enables
			ctrlValid <= 1'b0;
			isBranch <= 1'b0;
			npcOp <= ctrlPkg::NpcSeq;
			inDelaySlot <= 1'b0;
			dmRd <= 1'b0;
			dmWr <= 1'b0;
			dcacheEn <= 1'b0;
			hiloWr <= 1'b0;
			mduStart <= 1'b0;
			hiloBusy <= 1'b0;
			rfWr <= 1'b0;
			exception <= 1'b0;
			excCode <= ctrlPkg::ExcNone;
		end else begin
			ctrlValid <= 1'b1;
			isBranch <= isBranchDec;
			npcOp <= npcOpDec;
			inDelaySlot <= inDelaySlotDec;
			dmRd <= dmRdDec;
			dmWr <= dmWrDec;
			dcacheEn <= dcacheEnDec;
			hiloWr <= hiloWrDec;
			mduStart <= mduStartDec;
			hiloBusy <= hiloBusyDec;
			rfWr <= rfWrDec;
			exception <= exceptionDec;
			excCode <= excCodeDec;
		end
	end

	// Operation and select fields, qualified by the enables above
	always_ff @(posedge clk) begin
		if (instrValid) begin
			aluOp <= aluOpDec;
			shamtSel <= shamtSelDec;
			extOp <= extOpDec;
			immSrc <= immSrcDec;
			dmSize <= dmSizeDec;
			mduOp <= mduOpDec;
			hiloWrSel <= hiloWrSelDec;
			hiloRdHi <= hiloRdHiDec;
			dstSel <= dstSelDec;
			wbSel <= wbSelDec;
		end
	end

endmodule

/* verification/tbIdControl.sv */
module tbIdControl;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instrValid, rsEqRt, rsNeg, rsPos, flush, fetchExc;
	ctrlPkg::excCode_t fetchExcCode;
	logic ctrlValid, shamtSel, immSrc, isBranch, inDelaySlot, dmRd, dmWr, dcacheEn;
	logic hiloWr, mduStart, hiloRdHi, hiloBusy, rfWr, exception;
	ctrlPkg::aluOp_t aluOp;
	ctrlPkg::extOp_t extOp;
	ctrlPkg::npcOp_t npcOp;
	ctrlPkg::memSize_t dmSize;
	ctrlPkg::mduOp_t mduOp;
	ctrlPkg::hiloWrSel_t hiloWrSel;
	ctrlPkg::dstSel_t dstSel;
	ctrlPkg::wbSel_t wbSel;
	ctrlPkg::excCode_t excCode;

	logic [31:0] lfsr = 32'h483d1e93;
	int errorCount = 0;
	int issued = 0;
	int testCount = 0;
	// Expected values of the instruction on the bus, taken one edge later by $past
	logic shBranch, shDelay, prevBranch;
	ctrlPkg::npcOp_t shNpc;
	logic [5:0] shExc;

	idControl u_dut (.clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
		.rsEqRt(rsEqRt), .rsNeg(rsNeg), .rsPos(rsPos), .flush(flush), .fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode), .ctrlValid(ctrlValid), .aluOp(aluOp),
		.shamtSel(shamtSel), .extOp(extOp), .immSrc(immSrc), .isBranch(isBranch),
		.npcOp(npcOp), .inDelaySlot(inDelaySlot), .dmRd(dmRd), .dmWr(dmWr),
		.dmSize(dmSize), .dcacheEn(dcacheEn), .hiloWr(hiloWr), .mduStart(mduStart),
		.mduOp(mduOp), .hiloWrSel(hiloWrSel), .hiloRdHi(hiloRdHi), .hiloBusy(hiloBusy),
		.rfWr(rfWr), .dstSel(dstSel), .wbSel(wbSel), .exception(exception),
		.excCode(excCode));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//************************************************************************
	// Reference rules
	//************************************************************************

	function automatic logic isLoad(logic [31:0] i);
		return i[31:26] inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
	endfunction

	function automatic logic isStore(logic [31:0] i);
		return i[31:26] inside {6'h28, 6'h29, 6'h2b};
	endfunction

	function automatic logic isFn(logic [31:0] i, logic [5:0] fn);
		return i[31:26] == 6'h00 && i[5:0] == fn;
	endfunction

	function automatic ctrlPkg::memSize_t expSize(logic [31:0] i);
		case (i[31:26])
			6'h20: return ctrlPkg::MemLb;
			6'h21: return ctrlPkg::MemLh;
			6'h23: return ctrlPkg::MemLw;
			6'h24: return ctrlPkg::MemLbu;
			6'h25: return ctrlPkg::MemLhu;
			6'h28: return ctrlPkg::MemSb;
			6'h29: return ctrlPkg::MemSh;
			default: return ctrlPkg::MemSw;
		endcase
	endfunction

	function automatic logic expBranch(logic [31:0] i);
		if (i[31:26] inside {6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07}) return 1'b1;
		if (i[31:26] == 6'h01) return i[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11};
		return isFn(i, 6'h08) || isFn(i, 6'h09);
	endfunction

	function automatic ctrlPkg::npcOp_t expNpc(logic [31:0] i, logic eq, logic neg, logic pos);
		logic take;
		take = 1'b0;
		case (i[31:26])
			6'h02, 6'h03: return ctrlPkg::NpcJump;
			6'h04: take = eq;
			6'h05: take = !eq;
			6'h06: take = !pos;
			6'h07: take = pos;
			6'h01: begin
				if (i[20:16] == 5'h01 || i[20:16] == 5'h11) take = !neg;
				if (i[20:16] == 5'h00 || i[20:16] == 5'h10) take = neg;
			end
			default: if (isFn(i, 6'h08) || isFn(i, 6'h09)) return ctrlPkg::NpcJumpReg;
		endcase
		return take ? ctrlPkg::NpcBranch : ctrlPkg::NpcSeq;
	endfunction

	function automatic logic [5:0] expExc(logic [31:0] i, logic dropped, logic fl, logic fe,
		logic [4:0] code);
		if (fe) return {1'b1, code};	// Fetch fault wins
		if (dropped && !fl) return {1'b1, ctrlPkg::ExcRi};
		if (isFn(i, 6'h0d)) return {1'b1, ctrlPkg::ExcBp};
		if (isFn(i, 6'h0c)) return {1'b1, ctrlPkg::ExcSys};
		return 6'd0;
	endfunction

	function automatic ctrlPkg::mduOp_t expMdu(logic [31:0] i);
		case (i[5:0])
			6'h18: return ctrlPkg::MduMult;
			6'h19: return ctrlPkg::MduMultu;
			6'h1a: return ctrlPkg::MduDiv;
			default: return ctrlPkg::MduDivu;
		endcase
	endfunction

	//************************************************************************
	// Checks
	//************************************************************************

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		errorCount++;
	endtask

	loadCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && isLoad($past(instr)) |->
		{dmRd, dmWr, rfWr, wbSel, dstSel, extOp, aluOp} == {3'b101, ctrlPkg::WbMem,
		ctrlPkg::DstRt, ctrlPkg::ExtSign, ctrlPkg::AluAdd})
		else mismatch("load {dmRd,dmWr,rfWr,wbSel,dstSel,extOp,aluOp}",
			32'({dmRd, dmWr, rfWr, wbSel, dstSel, extOp, aluOp}),
			32'({3'b101, ctrlPkg::WbMem, ctrlPkg::DstRt, ctrlPkg::ExtSign, ctrlPkg::AluAdd}));
	storeCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && isStore($past(instr)) |-> {dmRd, dmWr, rfWr} == 3'b010)
		else mismatch("store {dmRd,dmWr,rfWr}", 32'({dmRd, dmWr, rfWr}), 32'h2);
	sizeCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && (isLoad($past(instr)) || isStore($past(instr))) |->
		{dcacheEn, immSrc, dmSize} == {2'b11, expSize($past(instr))})
		else mismatch("{dcacheEn,immSrc,dmSize}", 32'({dcacheEn, immSrc, dmSize}),
			32'({2'b11, expSize($past(instr))}));
	oriCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && $past(instr[31:26]) == 6'h0d |->
		{immSrc, extOp} == {1'b1, ctrlPkg::ExtZero})
		else mismatch("{immSrc,extOp}", 32'({immSrc, extOp}), 32'({1'b1, ctrlPkg::ExtZero}));
	luiCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && $past(instr[31:26]) == 6'h0f |->
		{immSrc, wbSel} == {1'b1, ctrlPkg::WbUpper})
		else mismatch("{immSrc,wbSel}", 32'({immSrc, wbSel}), 32'({1'b1, ctrlPkg::WbUpper}));
	shamtCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && $past(instr[31:26]) == 6'h00 &&
		$past(instr[5:0]) inside {6'h02, 6'h20} |->
		{shamtSel, immSrc} == {$past(instr[5:0]) == 6'h02, 1'b0})
		else mismatch("{shamtSel,immSrc}", 32'({shamtSel, immSrc}),
			32'({$past(instr[5:0]) == 6'h02, 1'b0}));
	branchCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) |-> {isBranch, npcOp} == $past({shBranch, shNpc}))
		else mismatch("{isBranch,npcOp}", 32'({isBranch, npcOp}), 32'($past({shBranch, shNpc})));
	delayCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) |-> inDelaySlot == $past(shDelay))
		else mismatch("inDelaySlot", 32'(inDelaySlot), 32'($past(shDelay)));
	mduCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && $past(instr[31:26]) == 6'h00 &&
		$past(instr[5:0]) inside {6'h18, 6'h19, 6'h1a, 6'h1b} |->
		{mduStart, hiloWr, hiloWrSel, mduOp} == {2'b11, ctrlPkg::HiloMdu, expMdu($past(instr))})
		else mismatch("{mduStart,hiloWr,hiloWrSel,mduOp}",
			32'({mduStart, hiloWr, hiloWrSel, mduOp}),
			32'({2'b11, ctrlPkg::HiloMdu, expMdu($past(instr))}));
	mthiCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && isFn($past(instr), 6'h11) |->
		{hiloWr, hiloWrSel} == {1'b1, ctrlPkg::HiloHi})
		else mismatch("{hiloWr,hiloWrSel}", 32'({hiloWr, hiloWrSel}), 32'h5);
	mtloCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && isFn($past(instr), 6'h13) |->
		{hiloWr, hiloWrSel} == {1'b1, ctrlPkg::HiloLo})
		else mismatch("{hiloWr,hiloWrSel}", 32'({hiloWr, hiloWrSel}), 32'h4);
	mfhiCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && isFn($past(instr), 6'h10) |->
		{rfWr, hiloRdHi, wbSel} == {2'b11, ctrlPkg::WbHiLo})
		else mismatch("{rfWr,hiloRdHi,wbSel}", 32'({rfWr, hiloRdHi, wbSel}), 32'h18);
	hiloBusyCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) && $past(instr[31:26]) == 6'h00 &&
		$past(instr[5:0]) inside {6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b} |->
		hiloBusy)
		else mismatch("hiloBusy", 32'(hiloBusy), 32'h1);
	excCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) |-> {exception, excCode} == $past(shExc))
		else mismatch("{exception,excCode}", 32'({exception, excCode}), 32'($past(shExc)));
	validCheck: assert property (@(posedge clk) disable iff (!rst)
		$past(instrValid) |-> ctrlValid)
		else mismatch("ctrlValid", 32'(ctrlValid), 32'h1);
	idleCheck: assert property (@(posedge clk) disable iff (!rst)
		!$past(instrValid) |->
		{ctrlValid, rfWr, hiloWr, mduStart, dmRd, dmWr, isBranch, exception, dcacheEn,
		hiloBusy, npcOp} == {10'd0, ctrlPkg::NpcSeq})
		else mismatch("enables and npcOp after an empty slot",
			32'({ctrlValid, rfWr, hiloWr, mduStart, dmRd, dmWr, isBranch, exception, dcacheEn,
			hiloBusy, npcOp}), 32'({10'd0, ctrlPkg::NpcSeq}));

	//************************************************************************
	// Stimulus
	//************************************************************************

	task automatic getBits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Random rs, rd and shamt; rt and funct are random unless fixed
	task automatic makeInstr(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rtIn,
		input logic keepFn, input logic keepRt, output logic [31:0] word);
		logic [31:0] r;
		getBits(26, r);
		word = {op, r[25:21], keepRt ? rtIn : r[20:16], r[15:6], keepFn ? fn : r[5:0]};
	endtask

	task automatic issue(input logic [31:0] word, input logic dropped, input logic fl,
		input logic fe);
		logic [31:0] r;
		getBits(8, r);
		@(posedge clk);
		#2;
		instr = word;
		instrValid = 1'b1;
		{rsEqRt, rsNeg, rsPos} = r[2:0];
		flush = fl;
		fetchExc = fe;
		fetchExcCode = fe ? r[7:3] : ctrlPkg::ExcNone;
		shBranch = expBranch(word);
		shNpc = expNpc(word, r[2], r[1], r[0]);
		shDelay = prevBranch;
		prevBranch = shBranch;
		shExc = expExc(word, dropped, fl, fe, fetchExcCode);
		issued++;
	endtask

	task automatic idleSlot();
		@(posedge clk);
		#2;
		instrValid = 1'b0;
		flush = 1'b0;
		fetchExc = 1'b0;
	endtask

	// Lets the stage register empty before the next test
	task automatic drain();
		int n;
		idleSlot();
		n = 0;
		while (ctrlValid && n < 20) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (ctrlValid) begin
			$display("Timeout: ctrlValid never dropped after an empty slot");
			errorCount++;
		end
	endtask

	task automatic runOps(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rtIn,
		input logic keepFn, input logic keepRt, input int reps);
		logic [31:0] w;
		for (int k = 0; k < reps; k++) begin
			makeInstr(op, fn, rtIn, keepFn, keepRt, w);
			issue(w, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic report(input string name, input int errBefore, input int n);
		testCount++;
		$display("%-10s %0d instructions, %0d errors", name, n, errorCount - errBefore);
	endtask

	initial begin
		logic [31:0] w;
		int e0;
		int n0;
		rst = 1'b0;
		{instr, instrValid, rsEqRt, rsNeg, rsPos, flush, fetchExc} = '0;
		fetchExcCode = ctrlPkg::ExcNone;
		{shBranch, shDelay, prevBranch, shExc} = '0;
		shNpc = ctrlPkg::NpcSeq;
		repeat (8) @(posedge clk);
		#2 rst = 1'b1;
		repeat (2) idleSlot();	// Past the post-reset guard

		e0 = errorCount;
		n0 = issued;
		for (int k = 0; k < 8; k++) runOps(k[0] ? 6'h20 : 6'h23, 6'h0, 5'h0, 1'b0, 1'b0, 1);
		runOps(6'h21, 0, 0, 0, 0, 2);
		runOps(6'h24, 0, 0, 0, 0, 2);
		runOps(6'h25, 0, 0, 0, 0, 2);
		runOps(6'h28, 0, 0, 0, 0, 2);
		runOps(6'h29, 0, 0, 0, 0, 2);
		runOps(6'h2b, 0, 0, 0, 0, 2);
		runOps(6'h0d, 0, 0, 0, 0, 3);	// ORI
		runOps(6'h0f, 0, 0, 0, 0, 3);	// LUI
		runOps(6'h08, 0, 0, 0, 0, 2);
		runOps(6'h00, 6'h20, 0, 1, 0, 2);	// ADD
		runOps(6'h00, 6'h02, 0, 1, 0, 2);	// SRL
		drain();
		report("aluMem", e0, issued - n0);

		e0 = errorCount;
		n0 = issued;
		for (int k = 0; k < 6; k++) begin
			runOps(6'h04, 0, 0, 0, 0, 1);
			runOps(6'h05, 0, 0, 0, 0, 1);
			runOps(6'h06, 0, 0, 0, 0, 1);
			runOps(6'h07, 0, 0, 0, 0, 1);
			runOps(6'h01, 0, 5'h00, 0, 1, 1);
			runOps(6'h01, 0, 5'h01, 0, 1, 1);
			runOps(6'h01, 0, 5'h10, 0, 1, 1);
			runOps(6'h01, 0, 5'h11, 0, 1, 1);
			runOps(6'h00, 6'h21, 0, 1, 0, 1);	// Slot filler after a branch
		end
		runOps(6'h02, 0, 0, 0, 0, 2);
		runOps(6'h03, 0, 0, 0, 0, 2);
		runOps(6'h00, 6'h08, 0, 1, 0, 2);	// JR
		runOps(6'h00, 6'h09, 0, 1, 0, 2);	// JALR
		runOps(6'h00, 6'h25, 0, 1, 0, 1);
		drain();
		report("branch", e0, issued - n0);

		e0 = errorCount;
		n0 = issued;
		for (int k = 0; k < 8; k++) runOps(6'h00, 6'h18 + 6'(k % 4), 0, 1, 0, 1);
		runOps(6'h00, 6'h11, 0, 1, 0, 2);	// MTHI
		runOps(6'h00, 6'h13, 0, 1, 0, 2);	// MTLO
		runOps(6'h00, 6'h10, 0, 1, 0, 2);	// MFHI
		runOps(6'h00, 6'h12, 0, 1, 0, 2);	// MFLO
		drain();
		report("hilo", e0, issued - n0);

		e0 = errorCount;
		n0 = issued;
		runOps(6'h00, 6'h0d, 0, 1, 0, 2);	// BREAK
		runOps(6'h00, 6'h0c, 0, 1, 0, 2);	// SYSCALL
		for (int k = 0; k < 2; k++) begin
			makeInstr(6'h10, 0, 0, 0, 0, w);	// MFC0, MTC0, ERET
			issue(w, 1'b1, k[0], 1'b0);
			makeInstr(6'h22, 0, 0, 0, 0, w);	// LWL
			issue(w, 1'b1, k[0], 1'b0);
			makeInstr(6'h2a, 0, 0, 0, 0, w);	// SWL
			issue(w, 1'b1, k[0], 1'b0);
			makeInstr(6'h1c, 0, 0, 0, 0, w);	// SPECIAL2
			issue(w, 1'b1, k[0], 1'b0);
			makeInstr(6'h00, 6'h0a, 0, 1, 0, w);	// MOVZ
			issue(w, 1'b1, k[0], 1'b0);
		end
		makeInstr(6'h00, 6'h0d, 0, 1, 0, w);
		issue(w, 1'b0, 1'b0, 1'b1);	// Fetch fault over BREAK
		makeInstr(6'h22, 0, 0, 0, 0, w);
		issue(w, 1'b1, 1'b0, 1'b1);
		makeInstr(6'h23, 0, 0, 0, 0, w);
		issue(w, 1'b0, 1'b0, 1'b1);
		drain();
		report("exception", e0, issued - n0);

		e0 = errorCount;
		n0 = issued;
		for (int k = 0; k < 6; k++) begin
			runOps(6'h23, 0, 0, 0, 0, 1);
			idleSlot();
			runOps(6'h00, 6'h18, 0, 1, 0, 2);
			idleSlot();
			idleSlot();
			runOps(6'h2b, 0, 0, 0, 0, 1);
		end
		drain();
		report("validIdle", e0, issued - n0);

		$display("tests %0d, instructions %0d, errors %0d", testCount, issued, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
hw/ctrlPkg.sv
hw/aluDecode.sv
hw/branchDecode.sv
hw/memDecode.sv
hw/hiloDecode.sv
hw/writebackDecode.sv
hw/excDecode.sv
hw/idControl.sv
verification/tbIdControl.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbIdControl -f build.f -o simv \
	> build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
